// File: src/hist_pkg.sv
/*
 * Histogram engine shared types
 * Memory opcodes, dump FSM states and the Wishbone word width
 */

package hist_pkg;

    // Wishbone address and data width
    localparam int WB_WIDTH = 32;

    // Count memory operations
    // Both return the old counter value
    typedef enum logic {
        MEM_INCR       = 1'b0,
        MEM_READ_CLEAR = 1'b1
    } mem_op_t;

    // Dump engine states
    typedef enum logic [1:0] {
        // Waiting for a dump request
        DUMP_IDLE  = 2'd0,
        // Read-clear handshake on the memory port
        DUMP_FETCH = 2'd1,
        // Wishbone write in progress
        DUMP_BUS   = 2'd2,
        // Bus released, step to the next bin
        DUMP_NEXT  = 2'd3
    } dump_state_t;

endpackage

// File: src/mem_port_if.sv
/*
 * Four-phase memory port
 * One requester and the arbiter share req/ack with op, addr and rdata
 */

`timescale 1ns/10ps

interface mem_port_if #(
    parameter int BIN_BITS    = 7,
    parameter int COUNT_WIDTH = 16
);

    logic                   req;
    logic                   ack;
    hist_pkg::mem_op_t      op;
    logic [BIN_BITS-1:0]    addr;
    // Old counter value, valid while ack is high
    logic [COUNT_WIDTH-1:0] rdata;

    modport requester (output req, op, addr, input ack, rdata);

    modport arbiter (input req, op, addr, output ack, rdata);

endinterface

// File: src/count_ram.sv
/*
 * Counter memory
 * One read-modify-write per valid pulse
 * Saturating increment or read-clear, old value returned a cycle later
 */

`timescale 1ns/10ps

module count_ram #(
    parameter int BIN_BITS    = 7,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  hist_pkg::mem_op_t      op,
    input  logic [BIN_BITS-1:0]    addr,
    output logic [COUNT_WIDTH-1:0] rdata
);

    localparam int NUM_BINS = 2 ** BIN_BITS;

    logic [COUNT_WIDTH-1:0] counts [NUM_BINS];

    // Counter update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counts <= '{default: '0};
        end else if (valid) begin
            if (op == hist_pkg::MEM_READ_CLEAR) begin
                counts[addr] <= '0;
            end else if (counts[addr] != '1) begin
                // Hold at all ones
                counts[addr] <= counts[addr] + 1'b1;
            end
        end
    end

    // Old value out, same edge as the update
    always_ff @(posedge clk) begin
        if (valid) begin
            rdata <= counts[addr];
        end
    end

endmodule

// File: src/mem_arbiter.sv
/*
 * Count memory arbiter
 * Two four-phase ports onto one RAM port, updater has fixed priority
 * Grant held for the whole handshake, one RAM pulse per grant
 */

`timescale 1ns/10ps

module mem_arbiter #(
    parameter int BIN_BITS    = 7,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_port_if.arbiter            upd,
    mem_port_if.arbiter            dmp,
    output logic                   ram_valid,
    output hist_pkg::mem_op_t      ram_op,
    output logic [BIN_BITS-1:0]    ram_addr,
    input  logic [COUNT_WIDTH-1:0] ram_rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_RAM,
        ARB_HOLD
    } arb_state_t;

    arb_state_t state;
    // High while the dump port owns the memory
    logic       grant_dmp;
    logic       owner_req;

    assign owner_req = grant_dmp ? dmp.req : upd.req;

    // Request fields from the owner, stable for the whole handshake
    assign ram_op   = grant_dmp ? dmp.op : upd.op;
    assign ram_addr = grant_dmp ? dmp.addr : upd.addr;

    // RAM output holds until the next pulse
    assign upd.rdata = ram_rdata;
    assign dmp.rdata = ram_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            grant_dmp <= 1'b0;
            ram_valid <= 1'b0;
            upd.ack   <= 1'b0;
            dmp.ack   <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Updater first
                    if (upd.req) begin
                        grant_dmp <= 1'b0;
                        ram_valid <= 1'b1;
                        state     <= ARB_RAM;
                    end else if (dmp.req) begin
                        grant_dmp <= 1'b1;
                        ram_valid <= 1'b1;
                        state     <= ARB_RAM;
                    end
                end
                ARB_RAM: begin
                    // RAM result lands with this edge
                    ram_valid <= 1'b0;
                    if (grant_dmp) begin
                        dmp.ack <= 1'b1;
                    end else begin
                        upd.ack <= 1'b1;
                    end
                    state <= ARB_HOLD;
                end
                ARB_HOLD: begin
                    // Release once the owner drops req
                    if (!owner_req) begin
                        upd.ack <= 1'b0;
                        dmp.ack <= 1'b0;
                        state   <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(upd.ack && dmp.ack))
        else $error("both memory ports acknowledged");

endmodule

// File: src/hist_updater.sv
/*
 * Histogram updater
 * Synchronizes the symbol strobe, keeps one pending symbol
 * and runs a four-phase increment per symbol, sticky overrun on loss
 */

`timescale 1ns/10ps

module hist_updater #(
    parameter int BIN_BITS = 7
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_strobe,
    input  logic [BIN_BITS-1:0] sample,
    output logic                overrun,
    mem_port_if.requester       mem
);

    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_REQ,
        UPD_RELEASE
    } upd_state_t;

    upd_state_t          state;

    // Strobe synchronizer and edge detect
    logic                strobe_meta;
    logic                strobe_sync;
    logic                strobe_prev;
    logic                sym_valid;

    // Pending slot
    logic                pend_valid;
    logic [BIN_BITS-1:0] pend_sym;
    logic                launch;

    assign sym_valid = strobe_sync & ~strobe_prev;
    // Pending symbol moves to the port when nothing is in flight
    assign launch    = (state == UPD_IDLE) && pend_valid;

    assign mem.op = hist_pkg::MEM_INCR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_meta <= 1'b0;
            strobe_sync <= 1'b0;
            strobe_prev <= 1'b0;
            pend_valid  <= 1'b0;
            overrun     <= 1'b0;
            mem.req     <= 1'b0;
            state       <= UPD_IDLE;
        end else begin
            strobe_meta <= sample_strobe;
            strobe_sync <= strobe_meta;
            strobe_prev <= strobe_sync;

            // Slot full and increment in flight, symbol lost
            if (sym_valid && pend_valid && !launch) begin
                overrun <= 1'b1;
            end
            if (sym_valid && (!pend_valid || launch)) begin
                pend_valid <= 1'b1;
            end else if (launch) begin
                pend_valid <= 1'b0;
            end

            case (state)
                UPD_IDLE: begin
                    if (pend_valid) begin
                        mem.req <= 1'b1;
                        state   <= UPD_REQ;
                    end
                end
                UPD_REQ: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        state   <= UPD_RELEASE;
                    end
                end
                UPD_RELEASE: begin
                    // Wait for ack low before next req
                    if (!mem.ack) begin
                        state <= UPD_IDLE;
                    end
                end
                default: state <= UPD_IDLE;
            endcase
        end
    end

    // Symbol and request address
    always_ff @(posedge clk) begin
        if (sym_valid && (!pend_valid || launch)) begin
            pend_sym <= sample;
        end
        if (launch) begin
            mem.addr <= pend_sym;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem.req && !mem.ack) |=> $stable(mem.addr))
        else $error("increment address changed during handshake");

endmodule

// File: src/wb_dump_engine.sv
/*
 * Histogram dump engine
 * Walks every bin with a read-clear on the memory port
 * and writes each old count to the bus as one Wishbone classic write
 */

`timescale 1ns/10ps

module wb_dump_engine #(
    parameter int                               BIN_BITS    = 7,
    parameter int                               COUNT_WIDTH = 16,
    parameter logic [hist_pkg::WB_WIDTH-1:0]    BASE_ADDR   = 32'h3000_0000
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                dump_req,
    output logic                                busy,
    output logic                                wb_cyc,
    output logic                                wb_stb,
    output logic                                wb_we,
    output logic [hist_pkg::WB_WIDTH/8-1:0]     wb_sel,
    output logic [hist_pkg::WB_WIDTH-1:0]       wb_adr,
    output logic [hist_pkg::WB_WIDTH-1:0]       wb_wdat,
    input  logic                                wb_ack,
    mem_port_if.requester                       mem
);

    typedef logic [hist_pkg::WB_WIDTH-1:0] wb_word_t;

    hist_pkg::dump_state_t state;
    logic                  dump_prev;
    logic                  dump_rise;
    // Current bin, also the memory address
    logic [BIN_BITS-1:0]   bin;

    assign dump_rise = dump_req & ~dump_prev;

    assign mem.op   = hist_pkg::MEM_READ_CLEAR;
    assign mem.addr = bin;
    // Full word writes only
    assign wb_sel   = '1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= hist_pkg::DUMP_IDLE;
            dump_prev <= 1'b0;
            bin       <= '0;
            busy      <= 1'b0;
            mem.req   <= 1'b0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
        end else begin
            dump_prev <= dump_req;
            case (state)
                hist_pkg::DUMP_IDLE: begin
                    // Edges while busy never get here
                    if (dump_rise) begin
                        bin     <= '0;
                        busy    <= 1'b1;
                        mem.req <= 1'b1;
                        state   <= hist_pkg::DUMP_FETCH;
                    end
                end
                hist_pkg::DUMP_FETCH: begin
                    // Count latched and bin cleared, start the write
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        wb_cyc  <= 1'b1;
                        wb_stb  <= 1'b1;
                        wb_we   <= 1'b1;
                        state   <= hist_pkg::DUMP_BUS;
                    end
                end
                hist_pkg::DUMP_BUS: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        state  <= hist_pkg::DUMP_NEXT;
                    end
                end
                hist_pkg::DUMP_NEXT: begin
                    // Bus idle this cycle; memory ack must be low too
                    if (!mem.ack) begin
                        if (&bin) begin
                            busy  <= 1'b0;
                            state <= hist_pkg::DUMP_IDLE;
                        end else begin
                            bin     <= bin + 1'b1;
                            mem.req <= 1'b1;
                            state   <= hist_pkg::DUMP_FETCH;
                        end
                    end
                end
                default: state <= hist_pkg::DUMP_IDLE;
            endcase
        end
    end

    // Address and data held until the next fetch completes
    always_ff @(posedge clk) begin
        if (state == hist_pkg::DUMP_FETCH && mem.ack) begin
            wb_adr  <= BASE_ADDR + (wb_word_t'(bin) << 2);
            wb_wdat <= wb_word_t'(mem.rdata);
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

endmodule

// File: src/hist_top.sv
/*
 * Symbol histogram top level
 * Updater and dump engine share the count memory through the arbiter
 * en gates new symbols and new dump requests
 */

`timescale 1ns/10ps

module hist_top #(
    parameter int                            BIN_BITS    = 7,
    parameter int                            COUNT_WIDTH = 16,
    parameter logic [hist_pkg::WB_WIDTH-1:0] BASE_ADDR   = 32'h3000_0000
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             en,
    input  logic                             sample_strobe,
    input  logic [BIN_BITS-1:0]              sample,
    input  logic                             dump_req,
    output logic                             busy,
    output logic                             overrun,
    // Wishbone master, writes only
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [hist_pkg::WB_WIDTH/8-1:0]  wb_sel,
    output logic [hist_pkg::WB_WIDTH-1:0]    wb_adr,
    output logic [hist_pkg::WB_WIDTH-1:0]    wb_wdat,
    // Unused, the engine never reads
    input  logic [hist_pkg::WB_WIDTH-1:0]    wb_rdat,
    input  logic                             wb_ack
);

    logic                   strobe_gated;
    logic                   dump_gated;
    logic                   ram_valid;
    hist_pkg::mem_op_t      ram_op;
    logic [BIN_BITS-1:0]    ram_addr;
    logic [COUNT_WIDTH-1:0] ram_rdata;

    // Started transactions finish regardless of en
    assign strobe_gated = sample_strobe & en;
    assign dump_gated   = dump_req & en;

    mem_port_if #(.BIN_BITS(BIN_BITS), .COUNT_WIDTH(COUNT_WIDTH)) upd_port ();
    mem_port_if #(.BIN_BITS(BIN_BITS), .COUNT_WIDTH(COUNT_WIDTH)) dmp_port ();

    hist_updater #(.BIN_BITS(BIN_BITS)) u_updater (
        .clk(clk), .rst_n(rst_n),
        .sample_strobe(strobe_gated), .sample(sample),
        .overrun(overrun), .mem(upd_port.requester)
    );

    wb_dump_engine #(
        .BIN_BITS(BIN_BITS), .COUNT_WIDTH(COUNT_WIDTH), .BASE_ADDR(BASE_ADDR)
    ) u_dump (
        .clk(clk), .rst_n(rst_n), .dump_req(dump_gated), .busy(busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
        .wb_adr(wb_adr), .wb_wdat(wb_wdat), .wb_ack(wb_ack),
        .mem(dmp_port.requester)
    );

    mem_arbiter #(.BIN_BITS(BIN_BITS), .COUNT_WIDTH(COUNT_WIDTH)) u_arbiter (
        .clk(clk), .rst_n(rst_n),
        .upd(upd_port.arbiter), .dmp(dmp_port.arbiter),
        .ram_valid(ram_valid), .ram_op(ram_op),
        .ram_addr(ram_addr), .ram_rdata(ram_rdata)
    );

    count_ram #(.BIN_BITS(BIN_BITS), .COUNT_WIDTH(COUNT_WIDTH)) u_ram (
        .clk(clk), .rst_n(rst_n), .valid(ram_valid),
        .op(ram_op), .addr(ram_addr), .rdata(ram_rdata)
    );

endmodule

// File: bench/hist_tb.sv
/*
 * Histogram engine testbench
 * LFSR symbols, Wishbone responder with random wait states,
 * saturating reference model and concurrent checks on every write
 */

`timescale 1ns/10ps

module hist_tb;

    localparam logic [31:0] BASE_ADDR   = 32'h3000_0000;
    localparam int          STROBE_GAP  = 12;
    localparam int          DUMP_CYCLES = 128 * STROBE_GAP;
    localparam int          DUMP_LIMIT  = 4 * DUMP_CYCLES;
    // Strobes and dumps over all tests
    localparam int          TEST_CYCLES = 610 * STROBE_GAP + 7 * DUMP_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        sample_strobe;
    logic [6:0]  sample;
    logic        dump_req;
    logic        busy;
    logic        overrun;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack = 1'b0;

    // Reference model and per-bin sums of accumulating dumps
    int          model [128] = '{default: 0};
    int          acc [128] = '{default: 0};
    logic [6:0]  exp_bin = '0;
    int          exp_count;
    int          writes_in_dump = 0;
    logic        wb_accept;
    // High when each write is compared, low when it is only summed
    logic        check_sum;

    logic [31:0] stim_lfsr = 32'h2a90;
    logic [31:0] resp_lfsr = 32'h2a90;
    logic        resp_armed = 1'b0;
    int          resp_wait = 0;
    int          resp_delay;

    string       test_name = "reset";
    int          assert_errors = 0;
    int          proc_errors = 0;
    int          errors_at_start;
    int          tests_passed = 0;
    int          tests_failed = 0;
    hist_pkg::dump_state_t dump_state;

    hist_top #(.COUNT_WIDTH(8)) UUT (
        .clk(clk), .rst_n(rst_n), .en(en),
        .sample_strobe(sample_strobe), .sample(sample), .dump_req(dump_req),
        .busy(busy), .overrun(overrun),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
        .wb_adr(wb_adr), .wb_wdat(wb_wdat), .wb_rdat(wb_rdat), .wb_ack(wb_ack)
    );

    assign wb_accept  = wb_cyc && wb_stb && wb_ack;
    assign exp_count  = model[exp_bin] - acc[exp_bin];
    assign dump_state = UUT.u_dump.state;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            val = (val << 1) | int'(state[0]);
        end
    endtask

    // Wishbone target with a random wait before each ack
    always @(posedge clk) begin
        if (wb_ack) begin
            wb_ack     <= 1'b0;
            resp_armed <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!resp_armed) begin
                draw_bits(resp_lfsr, 2, resp_delay);
                resp_wait  <= resp_delay;
                resp_armed <= 1'b1;
            end else if (resp_wait == 0) begin
                wb_ack <= 1'b1;
            end else begin
                resp_wait <= resp_wait - 1;
            end
        end
    end

    // Write count and a bin pointer that wraps after the last bin
    always @(posedge clk) begin
        if (!busy) begin
            writes_in_dump <= 0;
        end else if (wb_accept) begin
            writes_in_dump <= writes_in_dump + 1;
        end
        if (wb_accept) begin
            if (check_sum) begin
                acc[exp_bin] <= 0;
            end else begin
                acc[exp_bin] <= acc[exp_bin] + int'(wb_wdat);
            end
            exp_bin <= exp_bin + 7'd1;
        end
    end

    a_write_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wb_accept |-> wb_adr == BASE_ADDR + 32'(exp_bin) * 4)
        else begin
            assert_errors = assert_errors + 1;
            $display("MISMATCH %s: address expected %h actual %h", test_name,
                     BASE_ADDR + 32'($sampled(exp_bin)) * 4, $sampled(wb_adr));
        end

    a_write_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_accept && check_sum) |-> wb_wdat == 32'(exp_count))
        else begin
            assert_errors = assert_errors + 1;
            $display("MISMATCH %s: bin %0d count expected %0d actual %0d", test_name,
                     $sampled(exp_bin), $sampled(exp_count), $sampled(wb_wdat));
        end

    // Held write under back-pressure
    a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) &&
        $stable(wb_wdat) && $stable(wb_we) && $stable(wb_sel)))
        else begin
            assert_errors = assert_errors + 1;
            $display("%s: write dropped or changed before wb_ack", test_name);
        end

    // Bus released for a cycle after each ack
    a_bus_release: assert property (@(posedge clk) disable iff (!rst_n)
        wb_accept |=> (!wb_cyc && !wb_stb))
        else begin
            assert_errors = assert_errors + 1;
            $display("%s: bus cycle not released after wb_ack", test_name);
        end

    a_write_attrs: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> (wb_we && wb_sel == 4'hf && busy))
        else begin
            assert_errors = assert_errors + 1;
            $display("%s: write strobe without we, full sel or busy", test_name);
        end

    a_dump_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> writes_in_dump == 128)
        else begin
            assert_errors = assert_errors + 1;
            $display("MISMATCH %s: writes per dump expected 128 actual %0d", test_name,
                     $sampled(writes_in_dump));
        end

    a_dump_start: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(dump_req) && en && !busy) |=> busy)
        else begin
            assert_errors = assert_errors + 1;
            $display("%s: dump request did not raise busy", test_name);
        end

    a_dump_gated: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(dump_req) && !en && !busy) |=> !busy)
        else begin
            assert_errors = assert_errors + 1;
            $display("%s: dump started while en was low", test_name);
        end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n) !overrun)
        else begin
            assert_errors = assert_errors + 1;
            $display("%s: overrun set with spaced strobes", test_name);
        end

    // Random symbol when fixed_sym is negative
    task automatic send_symbols(input int count, input int fixed_sym, input bit counted);
        int         v;
        logic [6:0] sym;
        for (int i = 0; i < count; i++) begin
            if (fixed_sym < 0) begin
                draw_bits(stim_lfsr, 7, v);
            end else begin
                v = fixed_sym;
            end
            sym = 7'(v);
            @(posedge clk);
            sample        <= sym;
            sample_strobe <= 1'b1;
            repeat (2) @(posedge clk);
            sample_strobe <= 1'b0;
            repeat (STROBE_GAP - 3) @(posedge clk);
            if (counted && model[sym] < 255) begin
                model[sym] = model[sym] + 1;
            end
        end
    endtask

    task automatic pulse_dump();
        @(posedge clk);
        dump_req <= 1'b1;
        repeat (2) @(posedge clk);
        dump_req <= 1'b0;
    endtask

    task automatic start_dump(input bit compare);
        check_sum = compare;
        pulse_dump();
        @(negedge clk);
        if (!busy) begin
            proc_errors = proc_errors + 1;
            $display("%s: dump did not start", test_name);
        end
    endtask

    // Bounded wait for busy low
    // A compared dump empties the model
    task automatic finish_dump();
        int cycles;
        cycles = 0;
        while (busy && cycles < DUMP_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            proc_errors = proc_errors + 1;
            $display("%s: dump did not finish, state %s", test_name, dump_state.name());
        end
        repeat (2) @(negedge clk);
        if (check_sum) begin
            model = '{default: 0};
        end
    endtask

    task automatic run_dump(input bit compare);
        start_dump(compare);
        finish_dump();
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = assert_errors + proc_errors;
    endtask

    task automatic end_test();
        if (assert_errors + proc_errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail", test_name);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        en            = 1'b1;
        sample_strobe = 1'b0;
        sample        = '0;
        dump_req      = 1'b0;
        wb_rdat       = '0;
        check_sum     = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        begin_test("counting");
        send_symbols(200, -1, 1'b1);
        run_dump(1'b1);
        end_test();

        // Everything cleared by the first dump
        begin_test("read_clear");
        run_dump(1'b1);
        end_test();

        begin_test("bus_backpressure");
        send_symbols(30, -1, 1'b1);
        run_dump(1'b1);
        end_test();

        begin_test("saturation");
        send_symbols(300, 7'h55, 1'b1);
        run_dump(1'b1);
        end_test();

        // Symbols during a summed dump and a compared dump after it
        begin_test("concurrency");
        start_dump(1'b0);
        send_symbols(40, -1, 1'b1);
        finish_dump();
        run_dump(1'b1);
        end_test();

        begin_test("enable");
        @(posedge clk);
        en <= 1'b0;
        send_symbols(20, -1, 1'b0);
        pulse_dump();
        repeat (20) @(posedge clk);
        en <= 1'b1;
        send_symbols(20, -1, 1'b1);
        run_dump(1'b1);
        end_test();

        $display("tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, assert_errors + proc_errors);
        if (assert_errors + proc_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (TEST_CYCLES * 20) @(posedge clk);
        $display("watchdog: run exceeded %0d cycles in test %s", TEST_CYCLES * 20, test_name);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: build.f
src/hist_pkg.sv
src/mem_port_if.sv
src/count_ram.sv
src/mem_arbiter.sv
src/hist_updater.sv
src/wb_dump_engine.sv
src/hist_top.sv
bench/hist_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the histogram testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module hist_tb -f build.f -o hist_sim

output=$(./obj_dir/hist_sim)
echo "$output"

if echo "$output" | grep -q "Finished with no errors"; then
    exit 0
else
    exit 1
fi
